// ==== src/arm_ctrl_pkg.sv ====
package arm_ctrl_pkg;

    // Field widths of the instruction word.
    localparam int data_w     = 32;  // Datapath width.
    localparam int cond_w     = 4;   // Condition field.
    localparam int op_w       = 2;   // Op field.
    localparam int funct_w    = 6;   // Funct field, I bit down to S bit.
    localparam int rd_w       = 4;   // Destination register.
    localparam int cmd_w      = 4;   // Funct[4:1] on data processing.
    localparam int alu_ctrl_w = 2;   // ALU operation select.

    localparam logic [rd_w-1:0] rd_pc = 4'd15;  // R15 is the PC.

    // Data processing commands.
    localparam logic [cmd_w-1:0] cmd_and = 4'b0000;
    localparam logic [cmd_w-1:0] cmd_sub = 4'b0010;
    localparam logic [cmd_w-1:0] cmd_add = 4'b0100;
    localparam logic [cmd_w-1:0] cmd_cmp = 4'b1010;
    localparam logic [cmd_w-1:0] cmd_orr = 4'b1100;

    // ALU control codes.
    localparam logic [alu_ctrl_w-1:0] alu_add = 2'b00;
    localparam logic [alu_ctrl_w-1:0] alu_sub = 2'b01;
    localparam logic [alu_ctrl_w-1:0] alu_and = 2'b10;
    localparam logic [alu_ctrl_w-1:0] alu_orr = 2'b11;

    // Op field values.
    localparam logic [op_w-1:0] op_dp     = 2'b00;
    localparam logic [op_w-1:0] op_mem    = 2'b01;
    localparam logic [op_w-1:0] op_branch = 2'b10;

    // Condition codes, 1111 is left unused.
    localparam logic [cond_w-1:0] cond_eq = 4'b0000;  // Z set.
    localparam logic [cond_w-1:0] cond_ne = 4'b0001;  // Z clear.
    localparam logic [cond_w-1:0] cond_cs = 4'b0010;  // Unsigned higher or same.
    localparam logic [cond_w-1:0] cond_cc = 4'b0011;  // Unsigned lower.
    localparam logic [cond_w-1:0] cond_mi = 4'b0100;  // Negative.
    localparam logic [cond_w-1:0] cond_pl = 4'b0101;  // Positive or zero.
    localparam logic [cond_w-1:0] cond_vs = 4'b0110;  // Overflow.
    localparam logic [cond_w-1:0] cond_vc = 4'b0111;  // No overflow.
    localparam logic [cond_w-1:0] cond_hi = 4'b1000;  // Unsigned higher.
    localparam logic [cond_w-1:0] cond_ls = 4'b1001;  // Unsigned lower or same.
    localparam logic [cond_w-1:0] cond_ge = 4'b1010;  // Signed greater or equal.
    localparam logic [cond_w-1:0] cond_lt = 4'b1011;  // Signed less.
    localparam logic [cond_w-1:0] cond_gt = 4'b1100;  // Signed greater.
    localparam logic [cond_w-1:0] cond_le = 4'b1101;  // Signed less or equal.
    localparam logic [cond_w-1:0] cond_al = 4'b1110;  // Always.

    // Status flags, n in the top bit.
    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } nzcv_t;

endpackage

// ==== src/ctrl_if.sv ====
`timescale 1ns/1ns

// Decoder outputs shared by the ALU and the condition logic.
interface ctrl_if
    import arm_ctrl_pkg::*;
(
    input logic clk  // Only for assertion sampling.
);

    logic                  alu_op;       // Data processing, ALU decoder active.
    logic                  reg_w;        // Register write request.
    logic                  mem_w;        // Memory write request.
    logic                  pcs;          // PC write request.
    logic [alu_ctrl_w-1:0] alu_control;  // ALU operation.
    logic [1:0]            flag_w;       // [1] loads n,z and [0] loads c,v.
    logic                  no_write;     // CMP, keeps rd untouched.

    modport main_mp (output alu_op, reg_w, mem_w, pcs);

    modport alu_dec_mp (input clk, alu_op, output alu_control, flag_w, no_write);

    modport alu_mp (input alu_control);

    modport cond_mp (input reg_w, mem_w, pcs, flag_w, no_write);

endinterface

// ==== src/main_decoder.sv ====
`timescale 1ns/1ns

module main_decoder
    import arm_ctrl_pkg::*;
(
    input  logic [op_w-1:0]    op,
    input  logic [funct_w-1:0] funct,
    input  logic [rd_w-1:0]    rd,
    output logic               alu_src,     // Immediate as ALU operand b.
    output logic               mem_to_reg,  // Load data goes to rd.
    output logic [1:0]         imm_src,     // Extender format.
    output logic [1:0]         reg_src,     // Register file read selects.
    ctrl_if.main_mp            ctrl
);

    logic is_imm;   // I bit on data processing.
    logic is_load;  // L bit on memory.

    assign is_imm  = funct[funct_w-1];
    assign is_load = funct[0];

    always_comb begin
        // Nothing enabled unless the op says so.
        alu_src     = 1'b0;
        mem_to_reg  = 1'b0;
        imm_src     = 2'b00;
        reg_src     = 2'b00;
        ctrl.alu_op = 1'b0;
        ctrl.reg_w  = 1'b0;
        ctrl.mem_w  = 1'b0;

        case (op)
            op_dp: begin
                ctrl.reg_w  = 1'b1;    // ALU decoder may still veto it.
                ctrl.alu_op = 1'b1;
                alu_src     = is_imm;  // Register or rotated immediate.
            end
            op_mem: begin
                alu_src = 1'b1;        // Base plus 12-bit offset.
                imm_src = 2'b01;
                if (is_load) begin
                    ctrl.reg_w = 1'b1;
                    mem_to_reg = 1'b1;
                end else begin
                    ctrl.mem_w = 1'b1;
                    reg_src[1] = 1'b1;  // Store data read from rd.
                end
            end
            op_branch: begin
                alu_src    = 1'b1;     // PC plus offset.
                imm_src    = 2'b10;    // 24-bit branch offset.
                reg_src[0] = 1'b1;     // Read PC as operand a.
            end
            default: ;                 // Undefined op, no effect.
        endcase
    end

    // Branch, or any register write landing in R15.
    assign ctrl.pcs = (op == op_branch) | (ctrl.reg_w & (rd == rd_pc));

endmodule

// ==== src/alu_decoder.sv ====
`timescale 1ns/1ns

module alu_decoder
    import arm_ctrl_pkg::*;
(
    input logic [cmd_w:0] funct,  // cmd plus S bit.
    ctrl_if.alu_dec_mp    ctrl
);

    logic [cmd_w-1:0] cmd;
    logic             s_bit;

    assign cmd   = funct[cmd_w:1];
    assign s_bit = funct[0];

    always_comb begin
        ctrl.alu_control = alu_add;  // Address and branch target add.
        ctrl.flag_w      = 2'b00;
        ctrl.no_write    = 1'b0;

        if (ctrl.alu_op) begin
            case (cmd)
                cmd_add: begin
                    ctrl.alu_control = alu_add;
                    ctrl.flag_w      = {2{s_bit}};
                end
                cmd_sub: begin
                    ctrl.alu_control = alu_sub;
                    ctrl.flag_w      = {2{s_bit}};
                end
                cmd_and: begin
                    ctrl.alu_control = alu_and;
                    ctrl.flag_w      = {s_bit, 1'b0};  // Logic ops keep c,v.
                end
                cmd_orr: begin
                    ctrl.alu_control = alu_orr;
                    ctrl.flag_w      = {s_bit, 1'b0};
                end
                cmd_cmp: begin
                    ctrl.alu_control = alu_sub;        // Compare is a subtract.
                    ctrl.flag_w      = 2'b11;
                    ctrl.no_write    = 1'b1;           // Result thrown away.
                end
                default: ;                             // Unsupported, plain add.
            endcase
        end
    end

    // A discarded result must still leave its mark in the flags.
    a_no_write_flags: assert property (@(posedge ctrl.clk)
        ctrl.no_write |-> (ctrl.flag_w == 2'b11));

endmodule

// ==== src/alu.sv ====
`timescale 1ns/1ns

module alu
    import arm_ctrl_pkg::*;
(
    input  logic [data_w-1:0] src_a,
    input  logic [data_w-1:0] src_b,
    ctrl_if.alu_mp            ctrl,
    output logic [data_w-1:0] result,
    output nzcv_t             flags
);

    logic              is_sub;  // Subtract, invert b and carry in.
    logic              arith;   // Add or subtract.
    logic [data_w-1:0] b_eff;
    logic [data_w:0]   sum;     // Extra bit holds carry out.

    assign is_sub = (ctrl.alu_control == alu_sub);
    assign arith  = is_sub | (ctrl.alu_control == alu_add);
    assign b_eff  = is_sub ? ~src_b : src_b;
    assign sum    = {1'b0, src_a} + {1'b0, b_eff} + {{data_w{1'b0}}, is_sub};

    always_comb begin
        case (ctrl.alu_control)
            alu_add, alu_sub: result = sum[data_w-1:0];
            alu_and:          result = src_a & src_b;
            alu_orr:          result = src_a | src_b;
            default:          result = '0;
        endcase
    end

    assign flags.n = result[data_w-1];
    assign flags.z = (result == '0);
    assign flags.c = arith & sum[data_w];  // No borrow on subtract.
    // Operands of equal sign giving a result of the other sign.
    assign flags.v = arith & (src_a[data_w-1] == b_eff[data_w-1]) &
                     (sum[data_w-1] != src_a[data_w-1]);

endmodule

// ==== src/cond_logic.sv ====
`timescale 1ns/1ns

module cond_logic
    import arm_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic [cond_w-1:0] cond,
    input  nzcv_t             alu_flags,
    ctrl_if.cond_mp           ctrl,
    output logic              reg_write,
    output logic              mem_write,
    output logic              pc_src,
    output nzcv_t             flags      // Stored NZCV.
);

    logic cond_ex;  // Instruction executes.

    // Condition table on the stored flags.
    always_comb begin
        case (cond)
            cond_eq: cond_ex = flags.z;
            cond_ne: cond_ex = ~flags.z;
            cond_cs: cond_ex = flags.c;
            cond_cc: cond_ex = ~flags.c;
            cond_mi: cond_ex = flags.n;
            cond_pl: cond_ex = ~flags.n;
            cond_vs: cond_ex = flags.v;
            cond_vc: cond_ex = ~flags.v;
            cond_hi: cond_ex = flags.c & ~flags.z;
            cond_ls: cond_ex = ~flags.c | flags.z;
            cond_ge: cond_ex = (flags.n == flags.v);
            cond_lt: cond_ex = (flags.n != flags.v);
            cond_gt: cond_ex = ~flags.z & (flags.n == flags.v);
            cond_le: cond_ex = flags.z | (flags.n != flags.v);
            cond_al: cond_ex = 1'b1;
            default: cond_ex = 1'b0;  // Unused encoding.
        endcase
    end

    // Enables only take effect on a true condition.
    assign reg_write = ctrl.reg_w & cond_ex & ~ctrl.no_write;
    assign mem_write = ctrl.mem_w & cond_ex;
    assign pc_src    = ctrl.pcs & cond_ex;

    // Two halves, written independently.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flags <= '0;
        end else if (cond_ex) begin
            if (ctrl.flag_w[1]) begin
                flags.n <= alu_flags.n;
                flags.z <= alu_flags.z;
            end
            if (ctrl.flag_w[0]) begin
                flags.c <= alu_flags.c;
                flags.v <= alu_flags.v;
            end
        end
    end

    // Load and store requests from the main decoder exclude each other.
    a_one_write: assert property (@(posedge clk) disable iff (!rst_n)
        !(reg_write && mem_write));

endmodule

// ==== src/arm_exec_core.sv ====
`timescale 1ns/1ns

module arm_exec_core
    import arm_ctrl_pkg::*;
(
    input  logic               clk,
    input  logic               rst_n,
    input  logic [cond_w-1:0]  cond,
    input  logic [op_w-1:0]    op,
    input  logic [funct_w-1:0] funct,
    input  logic [rd_w-1:0]    rd,
    input  logic [data_w-1:0]  src_a,
    input  logic [data_w-1:0]  src_b,
    output logic [data_w-1:0]  alu_result,
    output logic               alu_src,
    output logic               mem_to_reg,
    output logic [1:0]         imm_src,
    output logic [1:0]         reg_src,
    output logic               reg_write,
    output logic               mem_write,
    output logic               pc_src,
    output nzcv_t              flags
);

    nzcv_t alu_flags;  // Unregistered ALU flags.

    ctrl_if u_ctrl (.clk(clk));

    main_decoder u_main_dec (
        .op         (op),
        .funct      (funct),
        .rd         (rd),
        .alu_src    (alu_src),
        .mem_to_reg (mem_to_reg),
        .imm_src    (imm_src),
        .reg_src    (reg_src),
        .ctrl       (u_ctrl.main_mp)
    );

    alu_decoder u_alu_dec (
        .funct (funct[cmd_w:0]),  // I bit not needed here.
        .ctrl  (u_ctrl.alu_dec_mp)
    );

    alu u_alu (
        .src_a  (src_a),
        .src_b  (src_b),
        .ctrl   (u_ctrl.alu_mp),
        .result (alu_result),
        .flags  (alu_flags)
    );

    cond_logic u_cond (
        .clk       (clk),
        .rst_n     (rst_n),
        .cond      (cond),
        .alu_flags (alu_flags),
        .ctrl      (u_ctrl.cond_mp),
        .reg_write (reg_write),
        .mem_write (mem_write),
        .pc_src    (pc_src),
        .flags     (flags)
    );

endmodule

// ==== test/exec_checker.sv ====
`timescale 1ns/1ns

// Compares the DUT outputs against the row the testbench is applying.
module exec_checker
    import arm_ctrl_pkg::*;
(
    input  logic              clk,
    input  logic              check_en,    // A row is being applied.
    input  int                test_no,
    input  logic [data_w-1:0] alu_result,
    input  logic              alu_src,
    input  logic              mem_to_reg,
    input  logic [1:0]        imm_src,
    input  logic [1:0]        reg_src,
    input  logic              reg_write,
    input  logic              mem_write,
    input  logic              pc_src,
    input  nzcv_t             flags,
    input  logic [data_w-1:0] exp_result,
    input  logic [2:0]        exp_en,      // reg_write, mem_write, pc_src.
    input  logic [5:0]        exp_ctl,     // alu_src, mem_to_reg, imm_src, reg_src.
    input  nzcv_t             exp_flags,   // Stored flags after the rising edge.
    output int                pass_count,
    output int                fail_count
);

    int row_errs;  // Mismatches in the current row.

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Error: test %0d %s got %0h expected %0h", test_no, name, got, exp);
            row_errs++;
        end
    endtask

    initial begin
        pass_count = 0;
        fail_count = 0;
        forever begin
            @(negedge clk);
            #1;  // Inputs driven on this edge have settled.
            if (check_en) begin
                row_errs = 0;
                compare_value("alu_result", alu_result, exp_result);
                compare_value("reg_write", 32'(reg_write), 32'(exp_en[2]));
                compare_value("mem_write", 32'(mem_write), 32'(exp_en[1]));
                compare_value("pc_src", 32'(pc_src), 32'(exp_en[0]));
                compare_value("alu_src", 32'(alu_src), 32'(exp_ctl[5]));
                compare_value("mem_to_reg", 32'(mem_to_reg), 32'(exp_ctl[4]));
                compare_value("imm_src", 32'(imm_src), 32'(exp_ctl[3:2]));
                compare_value("reg_src", 32'(reg_src), 32'(exp_ctl[1:0]));
                @(posedge clk);
                #1;  // Flags register has taken the update.
                compare_value("flags", 32'(flags), 32'(exp_flags));
                if (row_errs == 0) begin
                    $display("Test %0d passed", test_no);
                    pass_count++;
                end else begin
                    $display("Test %0d failed with %0d mismatches", test_no, row_errs);
                    fail_count++;
                end
            end
        end
    end

endmodule

// ==== test/tb_arm_exec_core.sv ====
`timescale 1ns/1ns

module tb_arm_exec_core
    import arm_ctrl_pkg::*;
();

    typedef struct packed {
        logic [cond_w-1:0]  cond;
        logic [op_w-1:0]    op;
        logic [funct_w-1:0] funct;
        logic [rd_w-1:0]    rd;
        logic [data_w-1:0]  a;
        logic [data_w-1:0]  b;
        logic [data_w-1:0]  res;
        logic [2:0]         en;     // reg_write, mem_write, pc_src.
        logic [5:0]         ctl;    // alu_src, mem_to_reg, imm_src, reg_src.
        nzcv_t              flg;    // Stored flags after the edge.
    } row_t;

    logic               clk;
    logic               rst_n;
    logic [cond_w-1:0]  cond;
    logic [op_w-1:0]    op;
    logic [funct_w-1:0] funct;
    logic [rd_w-1:0]    rd;
    logic [data_w-1:0]  src_a;
    logic [data_w-1:0]  src_b;
    logic [data_w-1:0]  alu_result;
    logic               alu_src;
    logic               mem_to_reg;
    logic [1:0]         imm_src;
    logic [1:0]         reg_src;
    logic               reg_write;
    logic               mem_write;
    logic               pc_src;
    nzcv_t              flags;
    logic [data_w-1:0]  exp_result;
    logic [2:0]         exp_en;
    logic [5:0]         exp_ctl;
    nzcv_t              exp_flags;
    logic               check_en;
    int                 test_no;
    int                 pass_count;
    int                 fail_count;
    row_t               rows[$];
    int                 seed;
    int                 limit;   // Timeout in cycles.
    int                 cycles;

    arm_exec_core i_dut (.*);

    exec_checker i_checker (.*);

    task automatic push_row(input logic [3:0] c, input logic [1:0] o, input logic [5:0] f,
                            input logic [3:0] d, input logic [31:0] a, input logic [31:0] b,
                            input logic [31:0] res, input logic [2:0] en,
                            input logic [5:0] ctl, input nzcv_t flg);
        rows.push_back({c, o, f, d, a, b, res, en, ctl, flg});
    endtask

    // Row columns are cond, op, funct, rd, src_a, src_b, result, enables, controls and nzcv.
    task automatic build_table();
        // Flags clear after reset.
        push_row(cond_eq, op_dp, 6'h08, 4'd1, 'h1, 'h2, 'h3, 3'b000, 6'b000000, 4'b0000);
        push_row(cond_al, op_dp, 6'h08, 4'd1, 'h1, 'h2, 'h3, 3'b100, 6'b000000, 4'b0000);
        push_row(cond_ne, op_dp, 6'h28, 4'd2, 'ha, 'h5, 'hf, 3'b100, 6'b100000, 4'b0000);
        push_row(cond_al, op_dp, 6'h04, 4'd3, 'ha, 'h3, 'h7, 3'b100, 6'b000000, 4'b0000);
        push_row(cond_al, op_dp, 6'h24, 4'd3, 'h3, 'ha, 'hffff_fff9, 3'b100, 6'b100000, 4'b0000);
        push_row(cond_al, op_dp, 6'h00, 4'd4, 'hf0f0, 'hff00, 'hf000, 3'b100, 6'b000000, 4'b0000);
        push_row(cond_al, op_dp, 6'h20, 4'd4, 'hff, 'hf, 'hf, 3'b100, 6'b100000, 4'b0000);
        push_row(cond_al, op_dp, 6'h18, 4'd5, 'hf0, 'hf, 'hff, 3'b100, 6'b000000, 4'b0000);
        push_row(cond_al, op_dp, 6'h38, 4'd5, 'h100, 'h1, 'h101, 3'b100, 6'b100000, 4'b0000);
        // S forms where logic ops keep c and v.
        push_row(cond_al, op_dp, 6'h09, 4'd6, 'h7fff_ffff, 'h1, 'h8000_0000, 3'b100, 6'b000000,
                 4'b1001);
        push_row(cond_al, op_dp, 6'h09, 4'd6, 'hffff_ffff, 'h1, 'h0, 3'b100, 6'b000000, 4'b0110);
        push_row(cond_al, op_dp, 6'h01, 4'd7, 'h8000_0000, 'hffff_ffff, 'h8000_0000, 3'b100,
                 6'b000000, 4'b1010);
        push_row(cond_al, op_dp, 6'h19, 4'd7, 'h0, 'h0, 'h0, 3'b100, 6'b000000, 4'b0110);
        push_row(cond_al, op_dp, 6'h05, 4'd8, 'h3, 'h5, 'hffff_fffe, 3'b100, 6'b000000, 4'b1000);
        // CMP of equal operands before EQ and NE rows.
        push_row(cond_al, op_dp, 6'h15, 4'd0, 'h7, 'h7, 'h0, 3'b000, 6'b000000, 4'b0110);
        push_row(cond_eq, op_dp, 6'h08, 4'd1, 'h1, 'h1, 'h2, 3'b100, 6'b000000, 4'b0110);
        push_row(cond_ne, op_dp, 6'h08, 4'd1, 'h2, 'h2, 'h4, 3'b000, 6'b000000, 4'b0110);
        push_row(cond_ne, op_dp, 6'h09, 4'd1, 'h7fff_ffff, 'h1, 'h8000_0000, 3'b000, 6'b000000,
                 4'b0110);
        // CMP 2 with 5 leaves n set and c clear.
        push_row(cond_al, op_dp, 6'h15, 4'd0, 'h2, 'h5, 'hffff_fffd, 3'b000, 6'b000000, 4'b1000);
        push_row(cond_lt, op_dp, 6'h08, 4'd2, 'h1, 'h2, 'h3, 3'b100, 6'b000000, 4'b1000);
        push_row(cond_cc, op_dp, 6'h04, 4'd2, 'h9, 'h4, 'h5, 3'b100, 6'b000000, 4'b1000);
        push_row(cond_mi, op_dp, 6'h18, 4'd2, 'h10, 'h1, 'h11, 3'b100, 6'b000000, 4'b1000);
        push_row(cond_ge, op_dp, 6'h08, 4'd2, 'h1, 'h1, 'h2, 3'b000, 6'b000000, 4'b1000);
        push_row(cond_cs, op_dp, 6'h09, 4'd2, 'hffff_ffff, 'h1, 'h0, 3'b000, 6'b000000, 4'b1000);
        // LDR, STR, B, write to R15, suppressed B.
        push_row(cond_al, op_mem, 6'h19, 4'd2, 'h100, 'h8, 'h108, 3'b100, 6'b110100, 4'b1000);
        push_row(cond_al, op_mem, 6'h18, 4'd3, 'h200, 'h4, 'h204, 3'b010, 6'b100110, 4'b1000);
        push_row(cond_al, op_branch, 6'h20, 4'd0, 'h1000, 'h20, 'h1020, 3'b001, 6'b101001,
                 4'b1000);
        push_row(cond_al, op_dp, 6'h08, 4'd15, 'h40, 'h4, 'h44, 3'b101, 6'b000000, 4'b1000);
        push_row(cond_eq, op_branch, 6'h20, 4'd0, 'h1000, 'h20, 'h1020, 3'b000, 6'b101001,
                 4'b1000);
    endtask

    // ADDS with AL so every flag follows the sum.
    task automatic add_random_rows();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] sum;
        longint      us;  // Operands added as unsigned numbers.
        longint      ss;  // Operands added as signed numbers.
        nzcv_t       f;
        repeat (32) begin
            a   = $random(seed);
            b   = $random(seed);
            r   = $random(seed);
            us  = longint'(a) + longint'(b);
            ss  = longint'(signed'(a)) + longint'(signed'(b));
            sum = us[31:0];
            // Carry and overflow mean the true sum leaves the 32-bit range.
            f   = {sum[31], sum == 32'h0, us > 64'sh0000_0000_ffff_ffff,
                   (ss > 64'sh7fff_ffff) || (ss < -64'sh8000_0000)};
            push_row(cond_al, op_dp, 6'h09, {1'b0, r[2:0]}, a, b, sum, 3'b100, 6'b000000, f);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        rst_n      = 1'b0;
        cond       = cond_al;
        op         = op_dp;
        funct      = '0;
        rd         = '0;
        src_a      = '0;
        src_b      = '0;
        exp_result = '0;
        exp_en     = '0;
        exp_ctl    = '0;
        exp_flags  = '0;
        check_en   = 1'b0;
        test_no    = 0;
        seed       = 32'h2f19_40c1;
        build_table();
        add_random_rows();
        limit = 2 * rows.size() + 40;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (rows[i]) begin
            @(negedge clk);
            cond       = rows[i].cond;
            op         = rows[i].op;
            funct      = rows[i].funct;
            rd         = rows[i].rd;
            src_a      = rows[i].a;
            src_b      = rows[i].b;
            exp_result = rows[i].res;
            exp_en     = rows[i].en;
            exp_ctl    = rows[i].ctl;
            exp_flags  = rows[i].flg;
            test_no    = i + 1;
            check_en   = 1'b1;
        end
        @(negedge clk);
        check_en = 1'b0;  // Last row was checked at the edge before.
        $display("Tests %0d, passed %0d, failed %0d", rows.size(), pass_count, fail_count);
        if (fail_count == 0 && pass_count == rows.size()) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Ends a run that never reaches the closing line.
    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the test sequence did not complete", cycles);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== sources.f ====
src/arm_ctrl_pkg.sv
src/ctrl_if.sv
src/main_decoder.sv
src/alu_decoder.sv
src/alu.sv
src/cond_logic.sv
src/arm_exec_core.sv
test/exec_checker.sv
test/tb_arm_exec_core.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --assert -j 0
TOP   = tb_arm_exec_core
FLIST = sources.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "\*\* PASS \*\*" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
